/* vlog.f */
alu_pkg.sv
alu_shift_unit.sv
alu_bitfield_unit.sv
alu_arith_unit.sv
alu_core.sv
alu_issue_queue.sv
alu_exec_top.sv
tb_alu_checker.sv
tb_alu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ALU execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_alu -f vlog.f --Mdir obj_dir -o tb_alu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_alu_sim)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' <<< "$sim_out"; then
    exit 0
fi
exit 1

/* tb_alu.sv */
`timescale 1ns/1ps

module tb_alu
    import alu_pkg::*;
();

    // Total operations including the directed ones
    localparam int n_ops          = 400;
    localparam int timeout_cycles = n_ops * 12 + 200;

    logic               clk = 1'b0;
    logic               arst_n;
    logic               in_valid;
    alu_op_e            in_op;
    logic [data_w-1:0]  in_a;
    logic [data_w-1:0]  in_b;
    logic [shamt_w-1:0] in_shamt;
    logic [shamt_w-1:0] in_rd;
    logic               in_credit;
    logic               out_valid;
    logic [data_w-1:0]  out_result;
    logic               out_zero;
    logic               out_great;
    logic               out_overflow;
    logic               out_credit;

    int seed         = 32'hda2cdeef;
    int prod_credits = queue_depth;
    int sent         = 0;
    int owed         = 0;
    int wait_left    = 0;
    int cycles       = 0;
    int mismatches;
    int protocol_errs;
    int issued;
    int received;

    alu_op_e op_list [21] = '{
        alu_add, alu_addu, alu_sub, alu_subu, alu_and, alu_or, alu_xor,
        alu_nor, alu_slt, alu_sltu, alu_lui, alu_sll, alu_srl, alu_sra,
        alu_sllv, alu_srlv, alu_srav, alu_rotr, alu_rotrv, alu_ins, alu_ext
    };

    ////////////////////////////////////////////////////////////
    // DUT and checker
    ////////////////////////////////////////////////////////////

    alu_exec_top dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_shamt     (in_shamt),
        .in_rd        (in_rd),
        .in_credit    (in_credit),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .out_zero     (out_zero),
        .out_great    (out_great),
        .out_overflow (out_overflow),
        .out_credit   (out_credit)
    );

    tb_alu_checker chk_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .in_a           (in_a),
        .in_b           (in_b),
        .in_shamt       (in_shamt),
        .in_rd          (in_rd),
        .in_credit      (in_credit),
        .out_valid      (out_valid),
        .out_result     (out_result),
        .out_zero       (out_zero),
        .out_great      (out_great),
        .out_overflow   (out_overflow),
        .out_credit     (out_credit),
        .mismatch_count (mismatches),
        .protocol_count (protocol_errs),
        .issued_count   (issued),
        .received_count (received)
    );

    // 20 ns period
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Producer
    ////////////////////////////////////////////////////////////

    // One credit back per in_credit pulse and one spent per beat
    always @(posedge clk) begin
        if (!arst_n) begin
            prod_credits = queue_depth;
        end else begin
            if (in_credit) begin
                prod_credits++;
            end
            if (in_valid) begin
                prod_credits--;
            end
        end
    end

    // One beat held off while out of credits
    task automatic send_op(
        input alu_op_e             op,
        input logic [data_w-1:0]   a,
        input logic [data_w-1:0]   b,
        input logic [shamt_w-1:0]  shamt,
        input logic [shamt_w-1:0]  rd
    );
        while (prod_credits == 0) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_op    = op;
        in_a     = a;
        in_b     = b;
        in_shamt = shamt;
        in_rd    = rd;
        sent++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Corner values now and then
    function automatic logic [data_w-1:0] pick_operand();
        int sel;
        sel = {$random(seed)} % 8;
        case (sel)
            0:       return 32'h0000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'hffff_ffff;
            default: return $random(seed);
        endcase
    endfunction

    task automatic send_random();
        int                 idx;
        logic [data_w-1:0]  a;
        logic [data_w-1:0]  b;
        // Idle on roughly 30% of cycles
        while ({$random(seed)} % 10 >= 7) begin
            @(posedge clk);
            #1;
        end
        idx = {$random(seed)} % 21;
        a   = pick_operand();
        b   = pick_operand();
        if ({$random(seed)} % 8 == 0) begin
            b = a;
        end
        send_op(op_list[idx], a, b, shamt_w'($random(seed)), shamt_w'($random(seed)));
    endtask

    // Fixed cases at the signed limits and field edges
    task automatic send_directed();
        send_op(alu_add,   32'h7fffffff, 32'h00000001, 5'd0,  5'd0);
        send_op(alu_add,   32'h80000000, 32'hffffffff, 5'd0,  5'd0);
        send_op(alu_sub,   32'h80000000, 32'h00000001, 5'd0,  5'd0);
        send_op(alu_sub,   32'h7fffffff, 32'hffffffff, 5'd0,  5'd0);
        send_op(alu_addu,  32'h7fffffff, 32'h00000001, 5'd0,  5'd0);
        send_op(alu_subu,  32'h00000000, 32'h00000001, 5'd0,  5'd0);
        send_op(alu_slt,   32'hffffffff, 32'h00000001, 5'd0,  5'd0);
        send_op(alu_sltu,  32'hffffffff, 32'h00000001, 5'd0,  5'd0);
        send_op(alu_lui,   32'h00000000, 32'h1234abcd, 5'd0,  5'd0);
        send_op(alu_rotr,  32'h00000000, 32'h12345678, 5'd8,  5'd0);
        send_op(alu_rotrv, 32'h00000004, 32'hdeadbeef, 5'd0,  5'd0);
        send_op(alu_sra,   32'h00000000, 32'h80000000, 5'd4,  5'd0);
        send_op(alu_ins,   32'h000000ff, 32'h00000000, 5'd4,  5'd11);
        send_op(alu_ins,   32'h000000ff, 32'ha5a5a5a5, 5'd10, 5'd3);
        send_op(alu_ext,   32'h12345678, 32'h00000000, 5'd28, 5'd7);
        send_op(alu_ext,   32'hdeadbeef, 32'h00000000, 5'd8,  5'd15);
        send_op(alu_nor,   32'h00000000, 32'h00000000, 5'd0,  5'd0);
        send_op(alu_sub,   32'h5a5a5a5a, 32'h5a5a5a5a, 5'd0,  5'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // Consumer
    ////////////////////////////////////////////////////////////

    // Slow phase in the middle forces back-pressure
    function automatic int next_delay();
        if ((sent >= 100) && (sent < 250)) begin
            return 3 + {$random(seed)} % 3;
        end
        return {$random(seed)} % 3;
    endfunction

    always @(posedge clk) begin
        if (arst_n && out_valid) begin
            owed++;
        end
        #1;
        out_credit = 1'b0;
        if (owed > 0) begin
            if (wait_left == 0) begin
                out_credit = 1'b1;
                owed--;
                wait_left = next_delay();
            end else begin
                wait_left--;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Timeout and main sequence
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("Timeout after %0d cycles, results stopped arriving (%0d of %0d)",
                     cycles, received, n_ops);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_op      = alu_add;
        in_a       = '0;
        in_b       = '0;
        in_shamt   = '0;
        in_rd      = '0;
        out_credit = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // A few idle edges with the queue empty
        repeat (3) @(posedge clk);
        #1;
        send_directed();
        while (sent < n_ops) begin
            send_random();
        end
        wait (received == n_ops);
        // Room for late or duplicated results
        repeat (10) @(posedge clk);
        $display("Errors: %0d mismatch, %0d protocol; issued %0d, received %0d",
                 mismatches, protocol_errs, issued, received);
        if ((mismatches == 0) && (protocol_errs == 0) && (issued == received)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb_alu_checker.sv */
`timescale 1ns/1ps

module tb_alu_checker
    import alu_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    // Producer side
    input  logic                in_valid,
    input  alu_op_e             in_op,
    input  logic [data_w-1:0]   in_a,
    input  logic [data_w-1:0]   in_b,
    input  logic [shamt_w-1:0]  in_shamt,
    input  logic [shamt_w-1:0]  in_rd,
    input  logic                in_credit,
    // Consumer side
    input  logic                out_valid,
    input  logic [data_w-1:0]   out_result,
    input  logic                out_zero,
    input  logic                out_great,
    input  logic                out_overflow,
    input  logic                out_credit,
    // Running totals
    output int                  mismatch_count,
    output int                  protocol_count,
    output int                  issued_count,
    output int                  received_count
);

    // One issued operation and what it should produce
    typedef struct packed {
        alu_op_e            op;
        logic [data_w-1:0]  a;
        logic [data_w-1:0]  b;
        logic [data_w-1:0]  result;
        logic               zero;
        logic               great;
        logic               overflow;
    } expect_t;

    expect_t  pending [$];
    expect_t  entry;
    expect_t  head;
    alu_op_e  cur_op;
    // Stage credits as seen from outside
    int       stage_credits = out_credits;
    int       credit_pulses = 0;

    initial begin
        mismatch_count = 0;
        protocol_count = 0;
        issued_count   = 0;
        received_count = 0;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [data_w-1:0] model_result(
        input alu_op_e             op,
        input logic [data_w-1:0]   a,
        input logic [data_w-1:0]   b,
        input logic [shamt_w-1:0]  shamt,
        input logic [shamt_w-1:0]  rd
    );
        logic [data_w-1:0] r;
        int lsb;
        int msb;
        int amt;
        int src;
        r   = '0;
        lsb = int'(shamt);
        msb = int'(rd);
        // Variable forms shift by a[4:0]
        if (op inside {alu_sllv, alu_srlv, alu_srav, alu_rotrv}) begin
            amt = int'(a[shamt_w-1:0]);
        end else begin
            amt = lsb;
        end
        case (op)
            alu_add, alu_addu: r = a + b;
            alu_sub, alu_subu: r = a - b;
            alu_and:           r = a & b;
            alu_or:            r = a | b;
            alu_xor:           r = a ^ b;
            alu_nor:           r = ~(a | b);
            alu_slt:           r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu:          r = (a < b) ? 32'd1 : 32'd0;
            alu_lui:           r = {b[15:0], 16'h0000};
            alu_sll, alu_sllv: r = b << amt;
            alu_srl, alu_srlv: r = b >> amt;
            alu_sra, alu_srav: r = $signed(b) >>> amt;
            // Bit i takes bit i+amt modulo the width
            alu_rotr, alu_rotrv: begin
                for (int i = 0; i < data_w; i++) begin
                    src  = (i + amt) % data_w;
                    r[i] = b[src];
                end
            end
            // Bits msb down to lsb of b replaced by low bits of a
            // Loop body never runs when msb < lsb
            alu_ins: begin
                r = b;
                for (int i = lsb; i <= msb; i++) begin
                    src  = i - lsb;
                    r[i] = a[src];
                end
            end
            // Low msb+1 bits of a shifted down by lsb
            // Bits past the top read as zero
            alu_ext: begin
                for (int i = 0; i <= msb; i++) begin
                    src = lsb + i;
                    if (src < data_w) begin
                        r[i] = a[src];
                    end
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    // Signed overflow for add and sub only
    function automatic logic model_overflow(
        input alu_op_e            op,
        input logic [data_w-1:0]  a,
        input logic [data_w-1:0]  b
    );
        logic [data_w-1:0] s;
        case (op)
            alu_add: begin
                s = a + b;
                return (a[data_w-1] == b[data_w-1]) && (s[data_w-1] != a[data_w-1]);
            end
            alu_sub: begin
                s = a - b;
                return (a[data_w-1] != b[data_w-1]) && (s[data_w-1] != a[data_w-1]);
            end
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Port monitor
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (arst_n) begin
            // Quiet outputs until something was sent
            if ((issued_count == 0) && (out_valid || in_credit)) begin
                protocol_count++;
                $display("Output activity before the first operation was issued at %0t",
                         $time);
            end
            if (in_valid) begin
                entry.op       = in_op;
                entry.a        = in_a;
                entry.b        = in_b;
                entry.result   = model_result(in_op, in_a, in_b, in_shamt, in_rd);
                entry.zero     = (entry.result == '0);
                entry.great    = $signed(in_a) > $signed(in_b);
                entry.overflow = model_overflow(in_op, in_a, in_b);
                pending.push_back(entry);
                issued_count++;
            end
            if (in_credit) begin
                credit_pulses++;
                if (credit_pulses > issued_count) begin
                    protocol_count++;
                    $display("in_credit pulsed more often than operations were issued at %0t",
                             $time);
                end
            end
            if (out_valid) begin
                received_count++;
                if (stage_credits == 0) begin
                    protocol_count++;
                    $display("Result sent while the stage held no consumer credit at %0t",
                             $time);
                end
                stage_credits--;
                if (pending.size() == 0) begin
                    protocol_count++;
                    $display("Result arrived with no operation outstanding at %0t", $time);
                end else begin
                    // Results keep issue order so the oldest op comes first
                    head   = pending.pop_front();
                    cur_op = head.op;
                    if ((out_result !== head.result) || (out_zero !== head.zero) ||
                        (out_great !== head.great) || (out_overflow !== head.overflow)) begin
                        mismatch_count++;
                        $display(
                            "mismatch at %0t: %s a=%h b=%h got %h zgv=%b%b%b exp %h zgv=%b%b%b",
                            $time, cur_op.name(), head.a, head.b,
                            out_result, out_zero, out_great, out_overflow,
                            head.result, head.zero, head.great, head.overflow);
                    end
                end
            end
            // Returned slot counts from the next edge on
            if (out_credit) begin
                stage_credits++;
            end
        end
    end

endmodule

/* alu_exec_top.sv */
`timescale 1ns/1ps

module alu_exec_top
    import alu_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    // Producer side
    input  logic                in_valid,
    input  alu_op_e             in_op,
    input  logic [data_w-1:0]   in_a,
    input  logic [data_w-1:0]   in_b,
    input  logic [shamt_w-1:0]  in_shamt,
    input  logic [shamt_w-1:0]  in_rd,
    output logic                in_credit,
    // Consumer side
    output logic                out_valid,
    output logic [data_w-1:0]   out_result,
    output logic                out_zero,
    output logic                out_great,
    output logic                out_overflow,
    input  logic                out_credit
);

    logic                pop;
    alu_op_e             head_op;
    logic [data_w-1:0]   head_a;
    logic [data_w-1:0]   head_b;
    logic [shamt_w-1:0]  head_shamt;
    logic [shamt_w-1:0]  head_rd;

    // Queue owns both credit loops
    alu_issue_queue queue_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_shamt   (in_shamt),
        .in_rd      (in_rd),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .pop        (pop),
        .head_op    (head_op),
        .head_a     (head_a),
        .head_b     (head_b),
        .head_shamt (head_shamt),
        .head_rd    (head_rd)
    );

    // Each pop issues the head, result one cycle later
    alu_core core_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue     (pop),
        .op        (head_op),
        .a         (head_a),
        .b         (head_b),
        .shamt     (head_shamt),
        .rd        (head_rd),
        .res_valid (out_valid),
        .result    (out_result),
        .zero      (out_zero),
        .great     (out_great),
        .overflow  (out_overflow)
    );

endmodule

/* alu_issue_queue.sv */
`timescale 1ns/1ps

module alu_issue_queue
    import alu_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  alu_op_e             in_op,
    input  logic [data_w-1:0]   in_a,
    input  logic [data_w-1:0]   in_b,
    input  logic [shamt_w-1:0]  in_shamt,
    input  logic [shamt_w-1:0]  in_rd,
    output logic                in_credit,
    input  logic                out_credit,
    output logic                pop,
    output alu_op_e             head_op,
    output logic [data_w-1:0]   head_a,
    output logic [data_w-1:0]   head_b,
    output logic [shamt_w-1:0]  head_shamt,
    output logic [shamt_w-1:0]  head_rd
);

    // Entry storage
    alu_op_e             op_mem    [queue_depth];
    logic [data_w-1:0]   a_mem     [queue_depth];
    logic [data_w-1:0]   b_mem     [queue_depth];
    logic [shamt_w-1:0]  shamt_mem [queue_depth];
    logic [shamt_w-1:0]  rd_mem    [queue_depth];

    logic [qptr_w-1:0]   wr_ptr;
    logic [qptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]    count;
    logic [cnt_w-1:0]    credits;

    ////////////////////////////////////////////////////////////
    // Storage and head read
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_mem[wr_ptr]    <= in_op;
            a_mem[wr_ptr]     <= in_a;
            b_mem[wr_ptr]     <= in_b;
            shamt_mem[wr_ptr] <= in_shamt;
            rd_mem[wr_ptr]    <= in_rd;
        end
    end

    assign head_op    = op_mem[rd_ptr];
    assign head_a     = a_mem[rd_ptr];
    assign head_b     = b_mem[rd_ptr];
    assign head_shamt = shamt_mem[rd_ptr];
    assign head_rd    = rd_mem[rd_ptr];

    // Head leaves when the consumer has room
    assign pop = (count != '0) && (credits != '0);

    ////////////////////////////////////////////////////////////
    // Pointers, occupancy and credits
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= cnt_w'(out_credits);
            in_credit <= 1'b0;
        end else begin
            // Pointers wrap with the power-of-two depth
            if (in_valid) begin
                wr_ptr <= wr_ptr + qptr_w'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + qptr_w'(1);
            end
            case ({in_valid, pop})
                2'b10:   count <= count + cnt_w'(1);
                2'b01:   count <= count - cnt_w'(1);
                default: count <= count;
            endcase
            // Returned credit and pop on one edge cancel
            case ({out_credit, pop})
                2'b10:   credits <= credits + cnt_w'(1);
                2'b01:   credits <= credits - cnt_w'(1);
                default: credits <= credits;
            endcase
            // Freed slot goes back to the producer
            in_credit <= pop;
        end
    end

    ////////////////////////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////////////////////////

    // Producer spent a credit it did not hold
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!arst_n)
        in_valid |-> (count != cnt_w'(queue_depth))
    ) else $error("alu_issue_queue: write while full");

    // Consumer returned more credits than it was given
    a_credit_max : assert property (
        @(posedge clk) disable iff (!arst_n)
        credits <= cnt_w'(out_credits)
    ) else $error("alu_issue_queue: credit count above limit");

    // Last credit spent and none returned, next cycle must hold
    a_last_credit : assert property (
        @(posedge clk) disable iff (!arst_n)
        (pop && (credits == cnt_w'(1)) && !out_credit) |=> !pop
    ) else $error("alu_issue_queue: pop without credit");

endmodule

/* alu_core.sv */
`timescale 1ns/1ps

module alu_core
    import alu_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue,
    input  alu_op_e             op,
    input  logic [data_w-1:0]   a,
    input  logic [data_w-1:0]   b,
    input  logic [shamt_w-1:0]  shamt,
    input  logic [shamt_w-1:0]  rd,
    output logic                res_valid,
    output logic [data_w-1:0]   result,
    output logic                zero,
    output logic                great,
    output logic                overflow
);

    logic [data_w-1:0] shift_res;
    logic [data_w-1:0] field_res;
    logic [data_w-1:0] arith_res;
    logic              arith_ovf;
    logic              arith_great;
    logic [data_w-1:0] next_result;
    logic              op_known;

    ////////////////////////////////////////////////////////////
    // Execution units
    ////////////////////////////////////////////////////////////

    alu_shift_unit shift_i (
        .op     (op),
        .b      (b),
        .shamt  (shamt),
        .a_low  (a[shamt_w-1:0]),
        .result (shift_res)
    );

    // rd carries the field msb, shamt the lsb
    alu_bitfield_unit field_i (
        .op     (op),
        .a      (a),
        .b      (b),
        .lsb    (shamt),
        .msb    (rd),
        .result (field_res)
    );

    alu_arith_unit arith_i (
        .op       (op),
        .a        (a),
        .b        (b),
        .result   (arith_res),
        .overflow (arith_ovf),
        .great    (arith_great)
    );

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////

    always_comb begin
        op_known    = 1'b1;
        next_result = '0;
        case (op)
            alu_and:  next_result = a & b;
            alu_or:   next_result = a | b;
            alu_xor:  next_result = a ^ b;
            alu_nor:  next_result = ~(a | b);
            // Low half of b into the upper half
            alu_lui:  next_result = {b[15:0], 16'h0000};
            alu_add, alu_addu, alu_sub, alu_subu,
            alu_slt, alu_sltu: begin
                next_result = arith_res;
            end
            alu_sll, alu_srl, alu_sra, alu_sllv, alu_srlv, alu_srav,
            alu_rotr, alu_rotrv: begin
                next_result = shift_res;
            end
            alu_ins, alu_ext: begin
                next_result = field_res;
            end
            default: begin
                op_known = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    // One-cycle valid after each issue
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue;
        end
    end

    // Result and flags load only on issue
    always_ff @(posedge clk) begin
        if (issue) begin
            result   <= next_result;
            zero     <= (next_result == '0);
            great    <= arith_great;
            overflow <= arith_ovf;
        end
    end

    // Every op popped from the queue must decode
    a_known_op : assert property (
        @(posedge clk) disable iff (!arst_n)
        issue |-> op_known
    ) else $error("alu_core: undefined op 0x%0h issued", op);

endmodule

/* alu_arith_unit.sv */
`timescale 1ns/1ps

module alu_arith_unit
    import alu_pkg::*;
(
    input  alu_op_e            op,
    input  logic [data_w-1:0]  a,
    input  logic [data_w-1:0]  b,
    output logic [data_w-1:0]  result,
    output logic               overflow,
    output logic               great
);

    logic                subtract;
    logic [data_w-1:0]   b_eff;
    logic [data_w:0]     sum;
    logic                sum_ovf;
    logic                lt_signed;
    logic                lt_unsigned;

    ////////////////////////////////////////////////////////////
    // Shared adder
    ////////////////////////////////////////////////////////////

    // Subtracts and compares run a + ~b + 1
    assign subtract = op inside {alu_sub, alu_subu, alu_slt, alu_sltu};
    assign b_eff    = subtract ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_eff} + {{data_w{1'b0}}, subtract};

    // Same input signs, different result sign
    assign sum_ovf  = (a[data_w-1] == b_eff[data_w-1]) &&
                      (sum[data_w-1] != a[data_w-1]);

    // Signed less-than corrects the sign by overflow
    assign lt_signed   = sum[data_w-1] ^ sum_ovf;
    // No carry out of a - b means a borrowed
    assign lt_unsigned = ~sum[data_w];

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            alu_slt:  result = {{(data_w-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(data_w-1){1'b0}}, lt_unsigned};
            default:  result = sum[data_w-1:0];
        endcase
    end

    // Only trapping forms report overflow
    assign overflow = sum_ovf && ((op == alu_add) || (op == alu_sub));
    assign great    = $signed(a) > $signed(b);

endmodule

/* alu_bitfield_unit.sv */
`timescale 1ns/1ps

module alu_bitfield_unit
    import alu_pkg::*;
(
    input  alu_op_e             op,
    input  logic [data_w-1:0]   a,
    input  logic [data_w-1:0]   b,
    input  logic [shamt_w-1:0]  lsb,
    input  logic [shamt_w-1:0]  msb,
    output logic [data_w-1:0]   result
);

    logic [data_w-1:0] low_mask;
    logic [data_w-1:0] field_mask;
    logic [data_w-1:0] ins_word;

    // Ones in bits msb down to 0
    // Two shifts so an msb of 31 gives all ones
    assign low_mask   = ~({data_w{1'b1}} << msb << 1);
    // Ones in bits msb down to lsb
    assign field_mask = low_mask & ({data_w{1'b1}} << lsb);

    // Low bits of a moved into the field of b
    // No mask bits when msb is below lsb so b passes unchanged
    assign ins_word = (b & ~field_mask) | ((a << lsb) & field_mask);

    always_comb begin
        case (op)
            alu_ins: begin
                result = ins_word;
            end
            // Zero-extended field of msb+1 bits from bit lsb of a
            alu_ext: begin
                result = (a >> lsb) & low_mask;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* alu_shift_unit.sv */
`timescale 1ns/1ps

module alu_shift_unit
    import alu_pkg::*;
(
    input  alu_op_e             op,
    input  logic [data_w-1:0]   b,
    input  logic [shamt_w-1:0]  shamt,
    input  logic [shamt_w-1:0]  a_low,
    output logic [data_w-1:0]   result
);

    logic                  variable;
    logic [shamt_w-1:0]    amount;
    logic [2*data_w-1:0]   rot_src;

    // Variable forms take the amount from a[4:0]
    assign variable = (op == alu_sllv) || (op == alu_srlv) ||
                      (op == alu_srav) || (op == alu_rotrv);
    assign amount   = variable ? a_low : shamt;

    // Rotate right by shifting a doubled copy of b
    assign rot_src  = {b, b} >> amount;

    always_comb begin
        case (op)
            alu_sll,
            alu_sllv: begin
                result = b << amount;
            end
            alu_srl,
            alu_srlv: begin
                result = b >> amount;
            end
            // Sign bit fills from the left
            alu_sra,
            alu_srav: begin
                result = $signed(b) >>> amount;
            end
            // Low half of the doubled word
            alu_rotr,
            alu_rotrv: begin
                result = rot_src[data_w-1:0];
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* alu_pkg.sv */
package alu_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////

    // Word width of operands and results
    localparam int data_w  = 32;
    // Shift amount and bit-field index width
    localparam int shamt_w = 5;
    // Operation code width
    localparam int op_w    = 6;

    ////////////////////////////////////////////////////////////
    // Flow control sizes
    ////////////////////////////////////////////////////////////

    // Input queue entries, also the producer credits after reset
    localparam int queue_depth = 4;
    // Consumer buffer slots, our credits after reset
    localparam int out_credits = 3;
    // Credit and occupancy counters
    localparam int cnt_w       = 3;
    // Queue read and write pointers
    localparam int qptr_w      = 2;

    ////////////////////////////////////////////////////////////
    // Operation codes
    ////////////////////////////////////////////////////////////

    typedef enum logic [op_w-1:0] {
        // Add and subtract family
        alu_add   = 6'h00,
        alu_addu  = 6'h01,
        alu_sub   = 6'h02,
        alu_subu  = 6'h03,
        // Bitwise logic
        alu_and   = 6'h04,
        alu_or    = 6'h05,
        alu_xor   = 6'h06,
        alu_nor   = 6'h07,
        // Compares and upper immediate
        alu_slt   = 6'h08,
        alu_sltu  = 6'h09,
        alu_lui   = 6'h0a,
        // Shifts by shamt
        alu_sll   = 6'h10,
        alu_srl   = 6'h11,
        alu_sra   = 6'h12,
        // Shifts by a[4:0]
        alu_sllv  = 6'h14,
        alu_srlv  = 6'h15,
        alu_srav  = 6'h16,
        // Rotates
        alu_rotr  = 6'h18,
        alu_rotrv = 6'h19,
        // Bit-field insert and extract
        alu_ins   = 6'h20,
        alu_ext   = 6'h21
    } alu_op_e;

endpackage
